// ==== fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    ////////////////////////////////////////
    // Basic word types
    ////////////////////////////////////////

    // Byte address
    typedef logic [31:0] addr_t;

    // One instruction word
    typedef logic [31:0] inst_t;

    // Fetched instruction on its way to the back end
    typedef struct packed {
        addr_t pc;
        inst_t word;
        logic  is_br;   // Direct branch B or BL
    } fetch_pkt_t;

    // Request to move the fetch PC
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    ////////////////////////////////////////
    // Wishbone classic signals
    ////////////////////////////////////////

    // Driven by the master
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
    } wb_req_t;

    // Driven by the slave
    typedef struct packed {
        inst_t dat;
        logic  ack;
    } wb_rsp_t;

    // Major opcodes of the direct branches
    localparam logic [5:0] OPC_B  = 6'b010100;
    localparam logic [5:0] OPC_BL = 6'b010101;

    typedef enum logic [1:0] {OP_B = 2'd0, OP_BL = 2'd1, OP_OTHER = 2'd2} br_op_e;

    typedef enum logic {IDLE = 1'b0, WAIT = 1'b1} fetch_state_e;

endpackage

`default_nettype wire

// ==== fe_pc_gen.sv ====
`default_nettype none

module fe_pc_gen import fe_pkg::*; #(
    parameter addr_t RESET_PC = 32'h1c00_0000
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire redirect_t ex_redirect,
    input  wire redirect_t pd_redirect,
    input  wire logic      fetch_accept,
    input  wire logic      ib_full,
    output addr_t          pc,
    output logic           pc_valid
);

    logic init_q;      // Low only in the first cycle after reset
    logic redir_q;     // A redirect was taken last cycle
    logic hold_pend;   // Predecode target parked while the buffer is full

    ////////////////////////////////////////
    // Fetch request qualifier
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            init_q  <= 1'b0;
            redir_q <= 1'b0;
        end else begin
            init_q  <= 1'b1;
            redir_q <= ex_redirect.valid | pd_redirect.valid;
        end
    end

    // No request right after reset, after a redirect, or while stalled
    assign pc_valid = init_q & ~redir_q & ~ib_full & ~hold_pend;

    ////////////////////////////////////////
    // Pending hold flag
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_pend <= 1'b0;
        end else if (ex_redirect.valid) begin
            // Back end flush supersedes any parked target
            hold_pend <= 1'b0;
        end else if (ib_full) begin
            if (pd_redirect.valid) begin
                hold_pend <= 1'b1;
            end
        end else begin
            hold_pend <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // PC register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (ex_redirect.valid) begin
            pc <= ex_redirect.target;
        end else if (pd_redirect.valid && !hold_pend) begin
            pc <= pd_redirect.target;
        end else if (hold_pend || ib_full) begin
            // Parked target must survive until the buffer drains
            pc <= pc;
        end else if (fetch_accept) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// ==== fe_fetch_wb.sv ====
`default_nettype none

module fe_fetch_wb import fe_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire addr_t     pc,
    input  wire logic      pc_valid,
    input  wire logic      ib_full,
    input  wire redirect_t ex_redirect,
    input  wire wb_rsp_t   wb_i,
    output wb_req_t        wb_o,
    output logic           fetch_accept,
    output logic           busy,
    output logic           rsp_valid,
    output fetch_pkt_t     rsp_pkt
);

    fetch_state_e state_q;
    addr_t        adr_q;    // Address of the open bus cycle
    logic         kill_q;   // Word of the open cycle is on a squashed path
    logic         ack;

    assign ack = wb_i.ack;

    // Start only from IDLE, never in a back-end redirect cycle
    assign fetch_accept = (state_q == IDLE) & pc_valid & ~ib_full & ~ex_redirect.valid;

    ////////////////////////////////////////
    // Bus cycle state machine
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE;
            kill_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    kill_q <= 1'b0;
                    if (fetch_accept) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (ack) begin
                        // Bus idles for at least one cycle after ack
                        state_q <= IDLE;
                        kill_q  <= 1'b0;
                    end else if (ex_redirect.valid) begin
                        kill_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Address latch held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            adr_q <= pc;
        end
    end

    ////////////////////////////////////////
    // Bus outputs
    ////////////////////////////////////////
    assign busy     = (state_q == WAIT);
    assign wb_o.cyc = busy;
    assign wb_o.stb = busy;
    assign wb_o.we  = 1'b0;   // Read only master
    assign wb_o.adr = adr_q;

    ////////////////////////////////////////
    // Response toward predecode
    ////////////////////////////////////////
    // Redirect in the ack cycle itself also drops the word
    assign rsp_valid     = busy & ack & ~kill_q & ~ex_redirect.valid;
    assign rsp_pkt.pc    = adr_q;
    assign rsp_pkt.word  = wb_i.dat;
    assign rsp_pkt.is_br = 1'b0;   // Filled in by predecode

endmodule

`default_nettype wire

// ==== fe_predecode.sv ====
`default_nettype none

module fe_predecode import fe_pkg::*; (
    input  wire logic       rsp_valid,
    input  wire fetch_pkt_t rsp_pkt,
    output fetch_pkt_t      ib_pkt,
    output logic            ib_push,
    output redirect_t       pd_redirect
);

    br_op_e      op;
    logic        is_br;
    logic [25:0] offs26;
    addr_t       br_off;

    ////////////////////////////////////////
    // Major opcode decode
    ////////////////////////////////////////
    always_comb begin
        case (rsp_pkt.word[31:26])
            OPC_B:   op = OP_B;
            OPC_BL:  op = OP_BL;
            default: op = OP_OTHER;
        endcase
    end

    assign is_br = (op == OP_B) | (op == OP_BL);

    // Split offset with offs[25:16] in bits 9:0 and offs[15:0] in bits 25:10
    assign offs26 = {rsp_pkt.word[9:0], rsp_pkt.word[25:10]};

    // Word offset to byte offset, sign extended
    assign br_off = {{4{offs26[25]}}, offs26, 2'b00};

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////
    always_comb begin
        ib_pkt       = rsp_pkt;
        ib_pkt.is_br = is_br;
    end

    assign ib_push = rsp_valid;

    // Same cycle as the ack of the branch
    assign pd_redirect.valid  = rsp_valid & is_br;
    assign pd_redirect.target = rsp_pkt.pc + br_off;

endmodule

`default_nettype wire

// ==== fe_instr_buf.sv ====
`default_nettype none

module fe_instr_buf import fe_pkg::*; #(
    parameter int IB_DEPTH = 4
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       push,
    input  wire fetch_pkt_t push_pkt,
    input  wire logic       busy,
    input  wire logic       flush,
    input  wire logic       deq_ready,
    output fetch_pkt_t      deq_pkt,
    output logic            deq_valid,
    output logic            ib_full
);

    localparam int PW = $clog2(IB_DEPTH);
    localparam int CW = PW + 1;

    fetch_pkt_t    mem [IB_DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] occ;
    logic          do_push;
    logic          do_pop;

    assign do_push = push & ~flush;
    assign do_pop  = deq_valid & deq_ready & ~flush;

    ////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PW'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PW'(1);
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    assign deq_valid = (count != '0);
    assign deq_pkt   = mem[rd_ptr];

    // Reserve a slot for the fetch still on the bus
    assign occ     = count + CW'(busy);
    assign ib_full = (occ == CW'(IB_DEPTH));

endmodule

`default_nettype wire

// ==== fe_frontend.sv ====
`default_nettype none

module fe_frontend import fe_pkg::*; #(
    parameter addr_t RESET_PC = 32'h1c00_0000,
    parameter int    IB_DEPTH = 4
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire wb_rsp_t   wb_i,
    input  wire redirect_t ex_redirect,
    input  wire logic      deq_ready,
    output wb_req_t        wb_o,
    output fetch_pkt_t     deq_pkt,
    output logic           deq_valid
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////
    addr_t      pc;
    logic       pc_valid;
    logic       fetch_accept;
    logic       busy;
    logic       ib_full;
    logic       rsp_valid;
    fetch_pkt_t rsp_pkt;
    fetch_pkt_t ib_pkt;
    logic       ib_push;
    redirect_t  pd_redirect;

    // PC stage
    fe_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk          (clk),
        .rstn         (rstn),
        .ex_redirect  (ex_redirect),
        .pd_redirect  (pd_redirect),
        .fetch_accept (fetch_accept),
        .ib_full      (ib_full),
        .pc           (pc),
        .pc_valid     (pc_valid)
    );

    // Bus master
    fe_fetch_wb u_fetch_wb (
        .clk          (clk),
        .rstn         (rstn),
        .pc           (pc),
        .pc_valid     (pc_valid),
        .ib_full      (ib_full),
        .ex_redirect  (ex_redirect),
        .wb_i         (wb_i),
        .wb_o         (wb_o),
        .fetch_accept (fetch_accept),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp_pkt      (rsp_pkt)
    );

    // Branch spotting on the returned word
    fe_predecode u_predecode (
        .rsp_valid   (rsp_valid),
        .rsp_pkt     (rsp_pkt),
        .ib_pkt      (ib_pkt),
        .ib_push     (ib_push),
        .pd_redirect (pd_redirect)
    );

    // Queue toward the back end that its redirect flushes
    fe_instr_buf #(
        .IB_DEPTH (IB_DEPTH)
    ) u_instr_buf (
        .clk       (clk),
        .rstn      (rstn),
        .push      (ib_push),
        .push_pkt  (ib_pkt),
        .busy      (busy),
        .flush     (ex_redirect.valid),
        .deq_ready (deq_ready),
        .deq_pkt   (deq_pkt),
        .deq_valid (deq_valid),
        .ib_full   (ib_full)
    );

endmodule

`default_nettype wire

// ==== tb_frontend_asserts.sv ====
`default_nettype none

module tb_frontend_asserts import fe_pkg::*; #(
    parameter addr_t RESET_PC = 32'h1c00_0000
) (
    input wire logic       clk,
    input wire logic       rstn,
    input wire wb_rsp_t    wb_i,
    input wire redirect_t  ex_redirect,
    input wire logic       deq_ready,
    input wire wb_req_t    wb_o,
    input wire fetch_pkt_t deq_pkt,
    input wire logic       deq_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int    fail_cnt = 0;
    logic  pop;
    logic  stb_seen;     // First bus cycle already started
    logic  redir_seen;   // Back-end redirect since the last dequeue
    addr_t redir_tgt;
    addr_t prev_pc;
    logic  prev_br;

    // Word the memory holds at a given address
    function automatic inst_t rule_word(input addr_t a);
        if (a[5:2] == 4'd7) begin
            return {6'b010100, 16'h0010, 10'h000};
        end
        return {6'b000000, a[27:2]};
    endfunction

    // A flushed buffer moves nothing
    assign pop = deq_valid & deq_ready & ~ex_redirect.valid;

    ////////////////////////////////////////
    // Reference of the packet stream
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stb_seen   <= 1'b0;
            redir_seen <= 1'b0;
            redir_tgt  <= '0;
            prev_pc    <= RESET_PC - 32'd4;
            prev_br    <= 1'b0;
        end else begin
            if (wb_o.stb) begin
                stb_seen <= 1'b1;
            end
            if (ex_redirect.valid) begin
                redir_seen <= 1'b1;
                redir_tgt  <= ex_redirect.target;
            end else if (pop) begin
                redir_seen <= 1'b0;
                prev_pc    <= deq_pkt.pc;
                // Branch words sit at word 7 of each 64-byte block
                prev_br    <= (deq_pkt.pc[5:2] == 4'd7);
            end
        end
    end

    ////////////////////////////////////////
    // Bus rules
    ////////////////////////////////////////
    a_reset_idle: assert property (@(posedge clk) !rstn |-> !wb_o.cyc && !deq_valid)
        else begin
            $error("Bus cycle or packet active during reset at %0t", $time);
            fail_cnt++;
        end

    a_reset_adr: assert property (@(posedge clk) disable iff (!rstn)
        (wb_o.stb && !stb_seen) |-> (wb_o.adr == RESET_PC))
        else begin
            $error("Mismatch at %0t: first bus address is not the reset PC", $time);
            fail_cnt++;
        end

    a_read_only: assert property (@(posedge clk) disable iff (!rstn)
        (wb_o.cyc == wb_o.stb) && !wb_o.we)
        else begin
            $error("Wishbone cyc and stb differ or a write was issued at %0t", $time);
            fail_cnt++;
        end

    a_adr_stable: assert property (@(posedge clk) disable iff (!rstn)
        (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)))
        else begin
            $error("Wishbone cycle dropped or address moved before ack at %0t", $time);
            fail_cnt++;
        end

    a_ack_gap: assert property (@(posedge clk) disable iff (!rstn) wb_i.ack |=> !wb_o.stb)
        else begin
            $error("No idle cycle on the bus after ack at %0t", $time);
            fail_cnt++;
        end

    ////////////////////////////////////////
    // Packet stream rules
    ////////////////////////////////////////
    a_word: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> (deq_pkt.word == rule_word(deq_pkt.pc))
            && (deq_pkt.is_br == (deq_pkt.pc[5:2] == 4'd7)))
        else begin
            $error("Mismatch at %0t: word or branch flag wrong for its pc", $time);
            fail_cnt++;
        end

    a_seq: assert property (@(posedge clk) disable iff (!rstn)
        (pop && !redir_seen && !prev_br) |-> (deq_pkt.pc == prev_pc + 32'd4))
        else begin
            $error("Mismatch at %0t: pc is not the previous pc plus 4", $time);
            fail_cnt++;
        end

    a_branch: assert property (@(posedge clk) disable iff (!rstn)
        (pop && !redir_seen && prev_br) |-> (deq_pkt.pc == prev_pc + 32'h40))
        else begin
            $error("Mismatch at %0t: pc after a branch is not its target", $time);
            fail_cnt++;
        end

    a_redirect: assert property (@(posedge clk) disable iff (!rstn)
        (pop && redir_seen) |-> (deq_pkt.pc == redir_tgt))
        else begin
            $error("Mismatch at %0t: pc after back-end redirect is not its target", $time);
            fail_cnt++;
        end

    // Stalled head must wait unchanged
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        (deq_valid && !deq_ready && !ex_redirect.valid) |=> (deq_valid && $stable(deq_pkt)))
        else begin
            $error("Stalled packet vanished or changed at %0t", $time);
            fail_cnt++;
        end

endmodule

bind fe_frontend tb_frontend_asserts #(
    .RESET_PC (RESET_PC)
) u_asserts (
    .clk         (clk),
    .rstn        (rstn),
    .wb_i        (wb_i),
    .ex_redirect (ex_redirect),
    .deq_ready   (deq_ready),
    .wb_o        (wb_o),
    .deq_pkt     (deq_pkt),
    .deq_valid   (deq_valid)
);

`default_nettype wire

// ==== tb_frontend.sv ====
`default_nettype none

module tb_frontend import fe_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t RESET_PC     = 32'h1c00_0000;
    localparam int    IB_DEPTH     = 4;
    localparam int    PERIOD       = 40;
    localparam int    RESET_CYCLES = 16;
    localparam int    N_PKT        = 200;
    localparam int    CYC_PER_PKT  = 50;   // Generous bound incl. stalls and flushes

    logic       clk         = 1'b0;
    logic       rstn        = 1'b0;
    wb_rsp_t    wb_i        = '0;
    redirect_t  ex_redirect = '0;
    logic       deq_ready   = 1'b0;
    wb_req_t    wb_o;
    fetch_pkt_t deq_pkt;
    logic       deq_valid;

    logic [31:0] rng_state = 32'd24;
    logic [1:0]  wait_cnt  = 2'd0;
    logic [3:0]  stall_cnt = 4'd0;
    int          n_deq     = 0;

    always #(PERIOD / 2) clk = ~clk;

    fe_frontend #(
        .RESET_PC (RESET_PC),
        .IB_DEPTH (IB_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .wb_i        (wb_i),
        .ex_redirect (ex_redirect),
        .deq_ready   (deq_ready),
        .wb_o        (wb_o),
        .deq_pkt     (deq_pkt),
        .deq_valid   (deq_valid)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // B with offset +0x40 at word 7 of each 64-byte block, else a tagged filler
    function automatic inst_t memory_word(input addr_t a);
        if (a[5:2] == 4'd7) begin
            return {6'b010100, 16'h0010, 10'h000};
        end
        return {6'b000000, a[27:2]};
    endfunction

    ////////////////////////////////////////
    // Memory slave and back-end model
    ////////////////////////////////////////
    always @(posedge clk) begin
        logic start_redir;
        rng_state   = lcg_next(rng_state);
        start_redir = (rng_state[31:28] == 4'd0) && !ex_redirect.valid;
        if (rstn) begin
            // Single-cycle ack after 0 to 3 wait states
            if (wb_i.ack) begin
                wb_i.ack <= 1'b0;
            end else if (wb_o.stb) begin
                if (wait_cnt == 2'd0) begin
                    wb_i.ack <= 1'b1;
                    wb_i.dat <= memory_word(wb_o.adr);
                    wait_cnt <= rng_state[27:26];
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
            // One-cycle back-end redirect into the reset page
            ex_redirect.valid <= start_redir;
            if (start_redir) begin
                ex_redirect.target <= {RESET_PC[31:12], rng_state[17:8], 2'b00};
            end
            // Stall bursts of 2 to 9 cycles
            if (start_redir) begin
                deq_ready <= 1'b0;
            end else if (stall_cnt != 4'd0) begin
                stall_cnt <= stall_cnt - 4'd1;
                deq_ready <= 1'b0;
            end else if (rng_state[25:22] == 4'd0) begin
                stall_cnt <= {1'b0, rng_state[21:19]} + 4'd1;
                deq_ready <= 1'b0;
            end else begin
                deq_ready <= 1'b1;
            end
        end
    end

    // Packets taken by the back end
    always @(posedge clk) begin
        if (rstn && deq_valid && deq_ready && !ex_redirect.valid) begin
            n_deq <= n_deq + 1;
        end
    end

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////
    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        wait (n_deq >= N_PKT);
        @(posedge clk);
        #1;
        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "Assertion failures were reported");
        end
    end

    // Stop at the first assertion failure
    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_cnt != 0) begin
            $display("Test FAILED");
            $fatal(1, "Stopped at the first assertion failure");
        end
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + N_PKT * CYC_PER_PKT) * PERIOD);
        $display("Timeout with %0d of %0d packets dequeued", n_deq, N_PKT);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// ==== fe_frontend.f ====
fe_pkg.sv
fe_pc_gen.sv
fe_fetch_wb.sv
fe_predecode.sv
fe_instr_buf.sv
fe_frontend.sv
tb_frontend_asserts.sv
tb_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_frontend -f fe_frontend.f -o tb_frontend; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1
